// ==== fc_svc_pkg.sv ====
package fc_svc_pkg;

  // ----------------------------------------
  // Service command codes
  // ----------------------------------------
  typedef enum logic [7:0] {
    CMD_FC_LCC_RESET               = 8'h10,
    CMD_LC_DISABLE_SVA             = 8'h11,
    CMD_LC_ENABLE_SVA              = 8'h12,
    CMD_FC_FORCE_ZEROIZATION       = 8'h20,
    CMD_FC_FORCE_ZEROIZATION_RESET = 8'h21,
    CMD_RELEASE_ZEROIZATION        = 8'h22,
    CMD_FC_TRIGGER_ESCALATION      = 8'h30,
    CMD_FC_LCC_EXT_CLK_160MHZ      = 8'h40,
    CMD_FC_LCC_EXT_CLK_400MHZ      = 8'h41,
    CMD_FC_LCC_EXT_CLK_500MHZ      = 8'h42,
    CMD_FC_LCC_EXT_CLK_1000MHZ     = 8'h43,
    CMD_FC_LCC_CORRECTABLE_FAULT   = 8'h50,
    CMD_FC_LCC_UNCORRECTABLE_FAULT = 8'h51
  } svc_cmd_e;

  typedef logic [7:0]  svc_cmd_t;
  typedef logic [11:0] clk_mhz_t;
  typedef logic [10:0] otp_addr_t;
  typedef logic [15:0] otp_word_t;

  // Frequency selected out of reset
  localparam clk_mhz_t CLK_MHZ_DEFAULT = 12'd1000;

  typedef enum logic [1:0] {
    FAULT_NONE   = 2'd0,
    FAULT_CORR   = 2'd1,
    FAULT_UNCORR = 2'd2
  } fault_mode_e;

  // ----------------------------------------
  // OTP partition map
  // ----------------------------------------
  localparam int NUM_PARTITIONS = 8;

  // First word address of each partition, in partition order
  localparam otp_addr_t PART_OFFSETS [NUM_PARTITIONS] = '{
    11'h000, 11'h024, 11'h048, 11'h050, 11'h058, 11'h060, 11'h260, 11'h4D4
  };

  // Length of the stretched fuse and life-cycle reset, in clock cycles
  localparam int RST_STRETCH_CYCLES = 11;

endpackage

// ==== fc_svc_cmd_if.sv ====
`timescale 1ns/1ps

interface fc_svc_cmd_if;
  import fc_svc_pkg::*;

  logic        vld;
  // One-hot command class, all low for an unknown code
  logic        is_reset;
  logic        is_sva_off;
  logic        is_sva_on;
  logic        is_zero_set;
  logic        is_zero_clr;
  logic        is_zero_rel;
  logic        is_esc;
  logic        is_clk;
  logic        is_fault;
  clk_mhz_t    clk_mhz;
  fault_mode_e fault_mode;

  modport src (
    output vld, is_reset, is_sva_off, is_sva_on, is_zero_set, is_zero_clr,
    output is_zero_rel, is_esc, is_clk, is_fault, clk_mhz, fault_mode
  );

  modport dst (
    input vld, is_reset, is_sva_off, is_sva_on, is_zero_set, is_zero_clr,
    input is_zero_rel, is_esc, is_clk, is_fault, clk_mhz, fault_mode
  );

endinterface

// ==== fc_svc_cmd_decode.sv ====
`timescale 1ns/1ps

module fc_svc_cmd_decode (
  input  logic                 clk,
  input  logic                 cptra_rst_b,
  input  logic                 cmd_valid_i,
  input  fc_svc_pkg::svc_cmd_t cmd_i,
  fc_svc_cmd_if.src            cmd
);
  import fc_svc_pkg::*;

  svc_cmd_e    code;
  logic        is_reset_d;
  logic        is_sva_off_d;
  logic        is_sva_on_d;
  logic        is_zero_set_d;
  logic        is_zero_clr_d;
  logic        is_zero_rel_d;
  logic        is_esc_d;
  logic        is_clk_d;
  logic        is_fault_d;
  clk_mhz_t    clk_mhz_d;
  fault_mode_e fault_mode_d;

  assign code = svc_cmd_e'(cmd_i);

  // Classify the raw code, flags stay low unless a command is strobed
  always_comb begin
    is_reset_d    = 1'b0;
    is_sva_off_d  = 1'b0;
    is_sva_on_d   = 1'b0;
    is_zero_set_d = 1'b0;
    is_zero_clr_d = 1'b0;
    is_zero_rel_d = 1'b0;
    is_esc_d      = 1'b0;
    is_clk_d      = 1'b0;
    is_fault_d    = 1'b0;
    clk_mhz_d     = CLK_MHZ_DEFAULT;
    fault_mode_d  = FAULT_NONE;
    if (cmd_valid_i) begin
      case (code)
        CMD_FC_LCC_RESET:               is_reset_d    = 1'b1;
        CMD_LC_DISABLE_SVA:             is_sva_off_d  = 1'b1;
        CMD_LC_ENABLE_SVA:              is_sva_on_d   = 1'b1;
        CMD_FC_FORCE_ZEROIZATION:       is_zero_set_d = 1'b1;
        CMD_FC_FORCE_ZEROIZATION_RESET: is_zero_clr_d = 1'b1;
        CMD_RELEASE_ZEROIZATION:        is_zero_rel_d = 1'b1;
        CMD_FC_TRIGGER_ESCALATION:      is_esc_d      = 1'b1;
        CMD_FC_LCC_EXT_CLK_160MHZ: begin
          is_clk_d  = 1'b1;
          clk_mhz_d = 12'd160;
        end
        CMD_FC_LCC_EXT_CLK_400MHZ: begin
          is_clk_d  = 1'b1;
          clk_mhz_d = 12'd400;
        end
        CMD_FC_LCC_EXT_CLK_500MHZ: begin
          is_clk_d  = 1'b1;
          clk_mhz_d = 12'd500;
        end
        CMD_FC_LCC_EXT_CLK_1000MHZ: begin
          is_clk_d  = 1'b1;
          clk_mhz_d = 12'd1000;
        end
        CMD_FC_LCC_CORRECTABLE_FAULT: begin
          is_fault_d   = 1'b1;
          fault_mode_d = FAULT_CORR;
        end
        CMD_FC_LCC_UNCORRECTABLE_FAULT: begin
          is_fault_d   = 1'b1;
          fault_mode_d = FAULT_UNCORR;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      cmd.vld         <= 1'b0;
      cmd.is_reset    <= 1'b0;
      cmd.is_sva_off  <= 1'b0;
      cmd.is_sva_on   <= 1'b0;
      cmd.is_zero_set <= 1'b0;
      cmd.is_zero_clr <= 1'b0;
      cmd.is_zero_rel <= 1'b0;
      cmd.is_esc      <= 1'b0;
      cmd.is_clk      <= 1'b0;
      cmd.is_fault    <= 1'b0;
    end else begin
      cmd.vld         <= cmd_valid_i;
      cmd.is_reset    <= is_reset_d;
      cmd.is_sva_off  <= is_sva_off_d;
      cmd.is_sva_on   <= is_sva_on_d;
      cmd.is_zero_set <= is_zero_set_d;
      cmd.is_zero_clr <= is_zero_clr_d;
      cmd.is_zero_rel <= is_zero_rel_d;
      cmd.is_esc      <= is_esc_d;
      cmd.is_clk      <= is_clk_d;
      cmd.is_fault    <= is_fault_d;
    end
  end

  // Command arguments only matter alongside their class flag
  always_ff @(posedge clk) begin
    if (cmd_valid_i) begin
      cmd.clk_mhz    <= clk_mhz_d;
      cmd.fault_mode <= fault_mode_d;
    end
  end

endmodule

// ==== fc_svc_ctrl_regs.sv ====
`timescale 1ns/1ps

module fc_svc_ctrl_regs #(
  parameter int RST_CYCLES = fc_svc_pkg::RST_STRETCH_CYCLES
) (
  input  logic                 clk,
  input  logic                 cptra_rst_b,
  fc_svc_cmd_if.dst            cmd,
  input  logic                 clk_byp_ack_i,
  output logic                 rst_req_o,
  output fc_svc_pkg::clk_mhz_t clk_sel_o,
  output logic                 ext_clk_req_o,
  output logic                 clk_switch_o,
  output logic                 zero_ovr_en_o,
  output logic                 zeroize_o,
  output logic [31:0]          rom_mask_o,
  output logic                 scrap_mode_o,
  output logic                 escalate_o,
  output logic                 sva_disable_o
);
  import fc_svc_pkg::*;

  localparam int CNT_W = (RST_CYCLES > 1) ? $clog2(RST_CYCLES) : 1;

  logic             rst_active_q;
  logic [CNT_W-1:0] rst_cnt_q;
  clk_mhz_t         clk_sel_q;
  logic             ext_clk_req_q;
  logic             zero_ovr_en_q;
  // High for the force-zeroization values, low for the force-reset values
  logic             zero_val_q;
  logic             escalate_q;
  logic             sva_disable_q;

  // ----------------------------------------
  // Fuse and life-cycle reset stretcher
  // ----------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst_active_q <= 1'b0;
      rst_cnt_q    <= '0;
    end else if (cmd.vld && cmd.is_reset && !rst_active_q) begin
      rst_active_q <= 1'b1;
      rst_cnt_q    <= '0;
    end else if (rst_active_q) begin
      // Last cycle of the pulse when the count reaches RST_CYCLES-1
      if (rst_cnt_q == CNT_W'(RST_CYCLES - 1)) begin
        rst_active_q <= 1'b0;
        rst_cnt_q    <= '0;
      end else begin
        rst_cnt_q <= rst_cnt_q + 1'b1;
      end
    end
  end

  assign rst_req_o = rst_active_q;

  // ----------------------------------------
  // External clock selection
  // ----------------------------------------
  assign clk_switch_o = ext_clk_req_q & clk_byp_ack_i;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_q     <= CLK_MHZ_DEFAULT;
      ext_clk_req_q <= 1'b0;
    end else begin
      if (clk_switch_o) begin
        ext_clk_req_q <= 1'b0;
      end
      // A new selection in the same cycle re-arms the request
      if (cmd.vld && cmd.is_clk) begin
        clk_sel_q     <= cmd.clk_mhz;
        ext_clk_req_q <= 1'b1;
      end
    end
  end

  assign clk_sel_o     = clk_sel_q;
  assign ext_clk_req_o = ext_clk_req_q;

  // ----------------------------------------
  // Overrides, escalation and SVA flag
  // ----------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      zero_ovr_en_q <= 1'b0;
      zero_val_q    <= 1'b0;
      escalate_q    <= 1'b0;
      sva_disable_q <= 1'b0;
    end else if (cmd.vld) begin
      if (cmd.is_zero_set) begin
        zero_ovr_en_q <= 1'b1;
        zero_val_q    <= 1'b1;
      end
      if (cmd.is_zero_clr) begin
        zero_ovr_en_q <= 1'b1;
        zero_val_q    <= 1'b0;
      end
      if (cmd.is_zero_rel) begin
        zero_ovr_en_q <= 1'b0;
      end
      // Escalation only clears with the block reset
      if (cmd.is_esc) begin
        escalate_q <= 1'b1;
      end
      if (cmd.is_sva_off) begin
        sva_disable_q <= 1'b1;
      end
      if (cmd.is_sva_on) begin
        sva_disable_q <= 1'b0;
      end
    end
  end

  // Value outputs read zero whenever the override is released
  assign zero_ovr_en_o = zero_ovr_en_q;
  assign zeroize_o     = zero_ovr_en_q & zero_val_q;
  assign rom_mask_o    = {32{zero_ovr_en_q & zero_val_q}};
  assign scrap_mode_o  = zero_ovr_en_q & ~zero_val_q;
  assign escalate_o    = escalate_q;
  assign sva_disable_o = sva_disable_q;

endmodule

// ==== fc_otp_fault_overlay.sv ====
`timescale 1ns/1ps

module fc_otp_fault_overlay (
  input  logic                                   clk,
  input  logic                                   cptra_rst_b,
  fc_svc_cmd_if.dst                              cmd,
  input  logic [fc_svc_pkg::NUM_PARTITIONS-1:0]  part_locked_i,
  input  logic                                   rd_valid_i,
  input  fc_svc_pkg::otp_addr_t                  rd_addr_i,
  input  fc_svc_pkg::otp_word_t                  rd_data_i,
  output logic                                   rd_valid_o,
  output fc_svc_pkg::otp_word_t                  rd_data_o
);
  import fc_svc_pkg::*;

  fault_mode_e fault_mode_q;
  logic        locked_hit;
  otp_word_t   flip_mask;
  logic        rd_valid_q;
  otp_word_t   rd_data_q;

  // ----------------------------------------
  // Fault mode, armed once per reset
  // ----------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_mode_q <= FAULT_NONE;
    end else if (cmd.vld && cmd.is_fault && (fault_mode_q == FAULT_NONE)) begin
      fault_mode_q <= cmd.fault_mode;
    end
  end

  // ----------------------------------------
  // Locked partition first-word match
  // ----------------------------------------
  always_comb begin
    locked_hit = 1'b0;
    for (int i = 0; i < NUM_PARTITIONS; i++) begin
      if ((rd_addr_i == PART_OFFSETS[i]) && part_locked_i[i]) begin
        locked_hit = 1'b1;
      end
    end
  end

  // A correctable fault flips one bit, an uncorrectable one flips the word
  always_comb begin
    flip_mask = '0;
    if (locked_hit) begin
      case (fault_mode_q)
        FAULT_CORR:   flip_mask = 16'h0001;
        FAULT_UNCORR: flip_mask = 16'hFFFF;
        default:      flip_mask = '0;
      endcase
    end
  end

  // ----------------------------------------
  // One-cycle read pipeline
  // ----------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid_i) begin
      rd_data_q <= rd_data_i ^ flip_mask;
    end
  end

  assign rd_valid_o = rd_valid_q;
  assign rd_data_o  = rd_data_q;

endmodule

// ==== fc_svc_top.sv ====
`timescale 1ns/1ps

module fc_svc_top #(
  parameter int RST_CYCLES = fc_svc_pkg::RST_STRETCH_CYCLES
) (
  input  logic                                   clk,
  input  logic                                   cptra_rst_b,
  input  logic                                   cmd_valid_i,
  input  fc_svc_pkg::svc_cmd_t                   cmd_i,
  input  logic                                   clk_byp_ack_i,
  input  logic [fc_svc_pkg::NUM_PARTITIONS-1:0]  part_locked_i,
  input  logic                                   rd_valid_i,
  input  fc_svc_pkg::otp_addr_t                  rd_addr_i,
  input  fc_svc_pkg::otp_word_t                  rd_data_i,
  output logic                                   rst_req_o,
  output fc_svc_pkg::clk_mhz_t                   clk_sel_o,
  output logic                                   ext_clk_req_o,
  output logic                                   clk_switch_o,
  output logic                                   zero_ovr_en_o,
  output logic                                   zeroize_o,
  output logic [31:0]                            rom_mask_o,
  output logic                                   scrap_mode_o,
  output logic                                   escalate_o,
  output logic                                   sva_disable_o,
  output logic                                   rd_valid_o,
  output fc_svc_pkg::otp_word_t                  rd_data_o
);

  // Decoded command bundle shared by the control and overlay stages
  fc_svc_cmd_if cmd_bus ();

  fc_svc_cmd_decode u_decode (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd         (cmd_bus)
  );

  fc_svc_ctrl_regs #(
    .RST_CYCLES (RST_CYCLES)
  ) u_ctrl_regs (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .cmd           (cmd_bus),
    .clk_byp_ack_i (clk_byp_ack_i),
    .rst_req_o     (rst_req_o),
    .clk_sel_o     (clk_sel_o),
    .ext_clk_req_o (ext_clk_req_o),
    .clk_switch_o  (clk_switch_o),
    .zero_ovr_en_o (zero_ovr_en_o),
    .zeroize_o     (zeroize_o),
    .rom_mask_o    (rom_mask_o),
    .scrap_mode_o  (scrap_mode_o),
    .escalate_o    (escalate_o),
    .sva_disable_o (sva_disable_o)
  );

  fc_otp_fault_overlay u_fault_overlay (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .cmd           (cmd_bus),
    .part_locked_i (part_locked_i),
    .rd_valid_i    (rd_valid_i),
    .rd_addr_i     (rd_addr_i),
    .rd_data_i     (rd_data_i),
    .rd_valid_o    (rd_valid_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

// ==== fc_svc_props.sv ====
`timescale 1ns/1ps

module fc_svc_props #(
  parameter int RST_CYCLES = fc_svc_pkg::RST_STRETCH_CYCLES
) (
  input logic clk,
  input logic cptra_rst_b,
  input logic rst_req_o,
  input logic ext_clk_req_o,
  input logic clk_switch_o,
  input logic zero_ovr_en_o,
  input logic zeroize_o,
  input logic escalate_o
);

  // Number of consecutive edges at which the stretched reset was seen high
  int rst_hi_cnt;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst_hi_cnt <= 0;
    end else if (rst_req_o) begin
      rst_hi_cnt <= rst_hi_cnt + 1;
    end else begin
      rst_hi_cnt <= 0;
    end
  end

  // ----------------------------------------
  // Control output properties
  // ----------------------------------------
  rst_len_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    rst_req_o |-> (rst_hi_cnt < RST_CYCLES))
    else $error("Fuse reset stayed high longer than %0d cycles", RST_CYCLES);

  clk_switch_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    clk_switch_o |-> ext_clk_req_o)
    else $error("Clock switch seen without a pending clock request");

  zeroize_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    zeroize_o |-> zero_ovr_en_o)
    else $error("Zeroize asserted while the override is disabled");

  // Escalation is sticky for as long as the block stays out of reset
  escalate_a: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    !$fell(escalate_o))
    else $error("Escalation dropped without a reset");

endmodule

bind fc_svc_ctrl_regs fc_svc_props #(
  .RST_CYCLES (RST_CYCLES)
) u_props (
  .clk           (clk),
  .cptra_rst_b   (cptra_rst_b),
  .rst_req_o     (rst_req_o),
  .ext_clk_req_o (ext_clk_req_o),
  .clk_switch_o  (clk_switch_o),
  .zero_ovr_en_o (zero_ovr_en_o),
  .zeroize_o     (zeroize_o),
  .escalate_o    (escalate_o)
);

// ==== fc_svc_tb.sv ====
`timescale 1ns/1ps

module fc_svc_tb;
  import fc_svc_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int RST_CYCLES   = RST_STRETCH_CYCLES;
  localparam int NUM_READS    = 64;
  // Two resets, the stretch test, four clock switches, the override and flag
  // steps and three read bursts, each counted with a little slack
  localparam int RUN_CYCLES = 2 * (RESET_CYCLES + 2) + (RST_CYCLES + 10) + 4 * 5
                              + 3 * 3 + 4 * 3 + 3 * (NUM_READS + 6) + 3 * 3;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + 200;

  logic                      clk;
  logic                      cptra_rst_b;
  logic                      cmd_valid_i;
  svc_cmd_t                  cmd_i;
  logic                      clk_byp_ack_i;
  logic [NUM_PARTITIONS-1:0] part_locked_i;
  logic                      rd_valid_i;
  otp_addr_t                 rd_addr_i;
  otp_word_t                 rd_data_i;
  logic                      rst_req_o;
  clk_mhz_t                  clk_sel_o;
  logic                      ext_clk_req_o;
  logic                      clk_switch_o;
  logic                      zero_ovr_en_o;
  logic                      zeroize_o;
  logic [31:0]               rom_mask_o;
  logic                      scrap_mode_o;
  logic                      escalate_o;
  logic                      sva_disable_o;
  logic                      rd_valid_o;
  otp_word_t                 rd_data_o;

  int          errors = 0;
  int          checks = 0;
  string       cur_test = "init";
  logic [31:0] rng_state = 32'h1af36764;

  fc_svc_top #(
    .RST_CYCLES (RST_CYCLES)
  ) UUT (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .clk_byp_ack_i (clk_byp_ack_i),
    .part_locked_i (part_locked_i),
    .rd_valid_i    (rd_valid_i),
    .rd_addr_i     (rd_addr_i),
    .rd_data_i     (rd_data_i),
    .rst_req_o     (rst_req_o),
    .clk_sel_o     (clk_sel_o),
    .ext_clk_req_o (ext_clk_req_o),
    .clk_switch_o  (clk_switch_o),
    .zero_ovr_en_o (zero_ovr_en_o),
    .zeroize_o     (zeroize_o),
    .rom_mask_o    (rom_mask_o),
    .scrap_mode_o  (scrap_mode_o),
    .escalate_o    (escalate_o),
    .sva_disable_o (sva_disable_o),
    .rd_valid_o    (rd_valid_o),
    .rd_data_o     (rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    end
  endtask

  // Present one command for a single cycle, then wait until its effect is visible
  task automatic issue_cmd(input svc_cmd_t code);
    @(negedge clk);
    cmd_valid_i = 1'b1;
    cmd_i       = code;
    @(negedge clk);
    cmd_valid_i = 1'b0;
    @(negedge clk);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    cptra_rst_b   = 1'b0;
    cmd_valid_i   = 1'b0;
    clk_byp_ack_i = 1'b0;
    rd_valid_i    = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    cptra_rst_b = 1'b1;
  endtask

  function automatic logic [63:0] output_snapshot();
    return 64'({rst_req_o, clk_sel_o, ext_clk_req_o, clk_switch_o, zero_ovr_en_o, zeroize_o,
                rom_mask_o, scrap_mode_o, escalate_o, sva_disable_o});
  endfunction

  // First word of a locked partition is corrupted according to the fault mode
  function automatic otp_word_t expected_word(input otp_addr_t addr, input otp_word_t data,
                                              input logic [7:0] locked, input fault_mode_e mode);
    otp_word_t flip;
    flip = '0;
    for (int i = 0; i < NUM_PARTITIONS; i++) begin
      if (addr == PART_OFFSETS[i] && locked[i]) begin
        if (mode == FAULT_CORR) begin
          flip = 16'h0001;
        end else if (mode == FAULT_UNCORR) begin
          flip = 16'hffff;
        end
      end
    end
    return data ^ flip;
  endfunction

  task automatic check_reset_values();
    check_val("rst_req_o", 64'(0), 64'(rst_req_o));
    check_val("clk_sel_o", 64'(1000), 64'(clk_sel_o));
    check_val("ext_clk_req_o", 64'(0), 64'(ext_clk_req_o));
    check_val("clk_switch_o", 64'(0), 64'(clk_switch_o));
    check_val("zero_ovr_en_o", 64'(0), 64'(zero_ovr_en_o));
    check_val("zeroize_o", 64'(0), 64'(zeroize_o));
    check_val("rom_mask_o", 64'(0), 64'(rom_mask_o));
    check_val("scrap_mode_o", 64'(0), 64'(scrap_mode_o));
    check_val("escalate_o", 64'(0), 64'(escalate_o));
    check_val("sva_disable_o", 64'(0), 64'(sva_disable_o));
    check_val("rd_valid_o", 64'(0), 64'(rd_valid_o));
  endtask

  // Back-to-back reads, every other one aimed at a partition offset
  task automatic run_reads(input fault_mode_e mode, input int n);
    otp_word_t   exp_q [$];
    otp_word_t   exp_word;
    logic [31:0] r;
    logic        prev_vld;
    otp_addr_t   addr;
    int          flips;
    prev_vld = 1'b0;
    flips    = 0;
    for (int i = 0; i <= n; i++) begin
      @(negedge clk);
      check_val("rd_valid_o", 64'(prev_vld), 64'(rd_valid_o));
      if (prev_vld) begin
        exp_word = exp_q.pop_front();
        check_val("rd_data_o", 64'(exp_word), 64'(rd_data_o));
      end
      if (i < n) begin
        r = next_rand();
        if (i % 2 == 0) begin
          addr = PART_OFFSETS[(i / 2) % NUM_PARTITIONS];
        end else begin
          addr = otp_addr_t'(next_rand());
        end
        part_locked_i = r[7:0];
        rd_valid_i    = 1'b1;
        rd_addr_i     = addr;
        rd_data_i     = r[31:16];
        exp_word      = expected_word(addr, r[31:16], r[7:0], mode);
        if (exp_word != r[31:16]) begin
          flips++;
        end
        exp_q.push_back(exp_word);
        prev_vld = 1'b1;
      end else begin
        rd_valid_i = 1'b0;
        prev_vld   = 1'b0;
      end
    end
    @(negedge clk);
    check_val("rd_valid_o after burst", 64'(0), 64'(rd_valid_o));
    assert (flips > 0) else begin
      errors++;
      $display("[ERROR] %s: no read hit a locked partition offset", cur_test);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset_stretch();
    int hi_cnt;
    int first_hi;
    int last_hi;
    cur_test = "reset_stretch";
    hi_cnt   = 0;
    first_hi = -1;
    last_hi  = -1;
    check_reset_values();
    @(negedge clk);
    cmd_valid_i = 1'b1;
    cmd_i       = CMD_FC_LCC_RESET;
    @(negedge clk);
    cmd_valid_i = 1'b0;
    // Only decode has taken the command at this point
    check_val("rst_req_o one edge after command", 64'(0), 64'(rst_req_o));
    for (int i = 0; i < RST_CYCLES + 6; i++) begin
      @(negedge clk);
      if (rst_req_o) begin
        if (first_hi < 0) begin
          first_hi = i;
        end
        last_hi = i;
        hi_cnt++;
      end
      // A second reset command lands in the middle of the stretch
      cmd_valid_i = (i == 3);
    end
    cmd_valid_i = 1'b0;
    check_val("stretch start", 64'(0), 64'(first_hi));
    check_val("stretch length", 64'(RST_CYCLES), 64'(hi_cnt));
    check_val("stretch end", 64'(RST_CYCLES - 1), 64'(last_hi));
  endtask

  task automatic test_clock_select();
    svc_cmd_t codes [4];
    int       freqs [4];
    codes = '{CMD_FC_LCC_EXT_CLK_160MHZ, CMD_FC_LCC_EXT_CLK_400MHZ,
              CMD_FC_LCC_EXT_CLK_500MHZ, CMD_FC_LCC_EXT_CLK_1000MHZ};
    freqs = '{160, 400, 500, 1000};
    cur_test = "clock_select";
    for (int k = 0; k < 4; k++) begin
      issue_cmd(codes[k]);
      check_val("clk_sel_o", 64'(freqs[k]), 64'(clk_sel_o));
      check_val("ext_clk_req_o", 64'(1), 64'(ext_clk_req_o));
      check_val("clk_switch_o before ack", 64'(0), 64'(clk_switch_o));
      clk_byp_ack_i = 1'b1;
      #1;
      check_val("clk_switch_o with ack", 64'(1), 64'(clk_switch_o));
      @(negedge clk);
      check_val("ext_clk_req_o after switch", 64'(0), 64'(ext_clk_req_o));
      check_val("clk_switch_o after switch", 64'(0), 64'(clk_switch_o));
      clk_byp_ack_i = 1'b0;
    end
  endtask

  task automatic test_zeroization();
    cur_test = "zeroization";
    issue_cmd(CMD_FC_FORCE_ZEROIZATION);
    check_val("set zero_ovr_en_o", 64'(1), 64'(zero_ovr_en_o));
    check_val("set zeroize_o", 64'(1), 64'(zeroize_o));
    check_val("set rom_mask_o", 64'(32'hffffffff), 64'(rom_mask_o));
    check_val("set scrap_mode_o", 64'(0), 64'(scrap_mode_o));
    issue_cmd(CMD_FC_FORCE_ZEROIZATION_RESET);
    check_val("reset zero_ovr_en_o", 64'(1), 64'(zero_ovr_en_o));
    check_val("reset zeroize_o", 64'(0), 64'(zeroize_o));
    check_val("reset rom_mask_o", 64'(0), 64'(rom_mask_o));
    check_val("reset scrap_mode_o", 64'(1), 64'(scrap_mode_o));
    issue_cmd(CMD_RELEASE_ZEROIZATION);
    check_val("release zero_ovr_en_o", 64'(0), 64'(zero_ovr_en_o));
    check_val("release zeroize_o", 64'(0), 64'(zeroize_o));
    check_val("release rom_mask_o", 64'(0), 64'(rom_mask_o));
    check_val("release scrap_mode_o", 64'(0), 64'(scrap_mode_o));
  endtask

  task automatic test_escalation_sva();
    logic [63:0] exp_outs;
    cur_test = "escalation_sva";
    issue_cmd(CMD_FC_TRIGGER_ESCALATION);
    check_val("escalate_o", 64'(1), 64'(escalate_o));
    issue_cmd(CMD_LC_DISABLE_SVA);
    check_val("sva_disable_o after disable", 64'(1), 64'(sva_disable_o));
    check_val("escalate_o after disable", 64'(1), 64'(escalate_o));
    issue_cmd(CMD_LC_ENABLE_SVA);
    check_val("sva_disable_o after enable", 64'(0), 64'(sva_disable_o));
    check_val("escalate_o after enable", 64'(1), 64'(escalate_o));
    // 1000 MHz selected and acknowledged, override released, escalation set, SVA enabled
    exp_outs = 64'({1'b0, 12'd1000, 1'b0, 1'b0, 1'b0, 1'b0,
                    32'h0, 1'b0, 1'b1, 1'b0});
    issue_cmd(8'hee);
    check_val("outputs after unknown code", exp_outs, output_snapshot());
  endtask

  task automatic test_overlay_corr();
    cur_test = "overlay_corr";
    issue_cmd(CMD_FC_LCC_CORRECTABLE_FAULT);
    run_reads(FAULT_CORR, NUM_READS);
  endtask

  task automatic test_overlay_uncorr();
    cur_test = "overlay_uncorr";
    apply_reset();
    check_reset_values();
    issue_cmd(CMD_FC_LCC_UNCORRECTABLE_FAULT);
    run_reads(FAULT_UNCORR, NUM_READS);
    // The mode is armed once, so this command must not take effect
    issue_cmd(CMD_FC_LCC_CORRECTABLE_FAULT);
    run_reads(FAULT_UNCORR, NUM_READS);
  endtask

  initial begin
    cptra_rst_b   = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_i         = '0;
    clk_byp_ack_i = 1'b0;
    part_locked_i = '0;
    rd_valid_i    = 1'b0;
    rd_addr_i     = '0;
    rd_data_i     = '0;
    apply_reset();
    test_reset_stretch();
    test_clock_select();
    test_zeroization();
    test_escalation_sva();
    test_overlay_corr();
    test_overlay_uncorr();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
fc_svc_pkg.sv
fc_svc_cmd_if.sv
fc_svc_cmd_decode.sv
fc_svc_ctrl_regs.sv
fc_otp_fault_overlay.sv
fc_svc_top.sv
fc_svc_props.sv
fc_svc_tb.sv

// ==== Makefile ====
# Verilator flow for the fuse-controller service block
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
TOP        ?= fc_svc_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass message shows up as a line of its own
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
